// File: tests/eth_rx_input.txt
# F <byte count> <good> <packet count after> <fcs xor mask>, then dest, source, length, payload
# the fcs is appended when driven, R = pointer reset, X = 200 random idle bytes
X
# good frame into slot 0
F 22 1 1 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 30 00 08
11 22 33 44 55 66 77 88
# corrupted fcs, slot 1 written then dropped
F 20 0 1 00000001
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 31 00 06
A0 A1 A2 A3 A4 A5
# good frame rewrites slot 1
F 19 1 2 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 32 00 05
B0 B1 B2 B3 B4
# foreign destination
F 18 0 2 00000000
1A 2B 3C 4D 5E 70 02 00 5E 10 20 33 00 04
C0 C1 C2 C3
# length 0x0500 is larger than a slot
F 18 0 2 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 34 05 00
D0 D1 D2 D3
# slot 2, count reaches 3
F 21 1 3 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 35 00 07
E0 E1 E2 E3 E4 E5 E6
# slot 3 twice, count saturated
F 18 1 3 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 36 00 04
F0 F1 F2 F3
F 20 1 3 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 37 00 06
5A 5B 5C 5D 5E 5F
X
R
# back to slot 0 after the pointer reset
F 17 1 1 00000000
1A 2B 3C 4D 5E 6F 02 00 5E 10 20 38 00 03
01 02 03

// File: vlog.f
+incdir+tests
logic/eth_frame_pkg.sv
logic/rx_buffer_pkg.sv
logic/rgmii_rx_ddr.sv
logic/eth_crc32.sv
logic/eth_rx_parser.sv
logic/rx_buffer_addr.sv
logic/eth_rx_top.sv
tests/tb_eth_rx.sv

// File: tests/tb_eth_rx_tasks.svh
    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic fail_run();
        failed = 1'b1;
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_mem_wr(input mem_wr_t got, input mem_wr_t exp, input string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b/%h/%h expected %b/%h/%h", $time, name,
                     got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
            fail_run();
        end
    endtask

    task automatic check_count(input pkt_count_t got, input pkt_count_t exp, input string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    //////////////////////////////////////////////////
    // pin driving and waits
    //////////////////////////////////////////////////

    // low nibble and dv settle before the rising edge, high nibble before the falling edge
    task automatic send_byte(input byte_t data, input logic dv);
        @(negedge eth_clk);
        #2;
        eth_dv  = dv;
        eth_rxd = data[3:0];
        @(posedge eth_clk);
        #2;
        eth_rxd = data[7:4];    // caught on the falling edge
    endtask

    task automatic send_idle(input int cycles);
        repeat (cycles) send_byte(8'h00, 1'b0);
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        @(negedge eth_clk);
        while (busy && n < 3000) begin
            @(negedge eth_clk);
            n++;
        end
        if (busy) begin
            $display("Timeout at %0t: o_busy stayed high for 3000 cycles", $time);
            fail_run();
        end
    endtask

// File: tests/tb_eth_rx.sv
`timescale 1ns/1ps

module tb_eth_rx
    import eth_frame_pkg::*, rx_buffer_pkg::*;
();

    logic       eth_clk;
    logic       rst;
    logic       rst_waddr;
    logic       eth_dv;
    logic [3:0] eth_rxd;
    mem_wr_t    mem_wr;
    logic       busy;
    logic       valid_packet;
    pkt_count_t packet_count;

    int        seed = 89;
    logic      failed = 1'b0;
    logic      mon_on = 1'b0;
    byte_t     frame_q[$];     // dest through payload, fcs added on the fly
    byte_t     exp_pay[$];
    buf_addr_t exp_base;
    mem_wr_t   exp_wr;
    int        model_count;
    int        wr_index;
    int        valid_seen;
    logic      busy_seen;
    logic      busy_prev;

    `include "tb_eth_rx_tasks.svh"

    eth_rx_top i_dut (
        .i_eth_clk      (eth_clk),
        .i_rst          (rst),
        .i_rst_waddr    (rst_waddr),
        .i_eth_dv       (eth_dv),
        .i_eth_rxd      (eth_rxd),
        .o_mem_wr       (mem_wr),
        .o_busy         (busy),
        .o_valid_packet (valid_packet),
        .o_packet_count (packet_count)
    );

    initial begin
        eth_clk = 1'b0;
        forever begin
            #10 eth_clk = ~eth_clk;
        end
    end

    //////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////

    always @(negedge eth_clk) begin
        if (mon_on) begin
            busy_seen = busy_seen | busy;
            if (valid_packet && (!busy_prev || busy)) begin
                $display("o_valid_packet pulsed at %0t without o_busy falling", $time);
                fail_run();
            end else if (valid_packet) begin
                valid_seen++;
            end
            if (mem_wr.we && wr_index >= exp_pay.size()) begin
                $display("unexpected payload write at %0t to address %h", $time, mem_wr.addr);
                fail_run();
            end else if (mem_wr.we) begin
                exp_wr.we   = 1'b1;
                exp_wr.addr = exp_base + buf_addr_t'(wr_index); // slot base plus index
                exp_wr.data = exp_pay[wr_index];
                check_mem_wr(mem_wr, exp_wr, "o_mem_wr");
                wr_index++;
            end
        end
        busy_prev = busy;
    end

    // 802.3 fcs, msb-first lfsr over the bits in wire order
    function automatic logic [31:0] frame_fcs();
        logic [31:0] lfsr;
        logic [31:0] rev;
        byte_t       cur;
        int          i;
        int          j;
        lfsr = 32'hFFFF_FFFF;
        for (i = 0; i < frame_q.size(); i++) begin
            cur = frame_q[i];
            for (j = 0; j < 8; j++) begin
                lfsr = {lfsr[30:0], 1'b0} ^ ((lfsr[31] ^ cur[j]) ? 32'h04C1_1DB7 : 32'h0);
            end
        end
        for (i = 0; i < 32; i++) begin
            rev[i] = lfsr[31-i];
        end
        return ~rev;
    endfunction

    task automatic run_frame(input int good, input int cnt, input logic [31:0] mask);
        logic [31:0]  fcs;
        mac_t         dest;
        payload_len_t len;
        int           i;
        for (i = 0; i < MAC_BYTES; i++) begin
            dest = {dest[39:0], frame_q[i]};
        end
        len = {frame_q[12], frame_q[13]};
        exp_pay.delete();
        if (dest == STATION_MAC && len != 0 && len <= SLOT_BYTES) begin
            for (i = 0; i < len && 14 + i < frame_q.size(); i++) begin
                exp_pay.push_back(frame_q[14 + i]);
            end
        end
        exp_base   = buf_addr_t'(model_count * SLOT_BYTES);
        wr_index   = 0;
        valid_seen = 0;
        busy_seen  = 1'b0;
        fcs        = frame_fcs() ^ mask;  // nonzero mask corrupts the fcs
        foreach (frame_q[i]) send_byte(frame_q[i], 1'b1);
        for (i = 0; i < FCS_BYTES; i++) begin
            send_byte(fcs[8*i +: 8], 1'b1);   // fcs goes out low byte first
        end
        send_idle(1);
        wait_busy_low();
        send_idle(12);                        // inter-frame gap
        check_bit(busy_seen, dest == STATION_MAC, "o_busy during frame");
        if (wr_index != exp_pay.size() || valid_seen != good) begin
            $display("Mismatch at %0t: writes/valid pulses got %0d/%0d expected %0d/%0d",
                     $time, wr_index, valid_seen, exp_pay.size(), good);
            fail_run();
        end
        if (good != 0 && model_count < NUM_SLOTS - 1) begin
            model_count++;   // last slot is reused once full
        end
        check_count(packet_count, pkt_count_t'(cnt), "o_packet_count");
    endtask

    task automatic request_ptr_reset();
        @(posedge eth_clk);
        #2;
        rst_waddr = 1'b1;
        repeat (3) @(posedge eth_clk);
        #2;
        rst_waddr = 1'b0;
        repeat (3) @(posedge eth_clk);
        model_count = 0;
        @(negedge eth_clk);
        check_count(packet_count, '0, "o_packet_count");
    endtask

    task automatic send_random_idle();
        int i;
        exp_pay.delete();
        wr_index  = 0;
        busy_seen = 1'b0;
        for (i = 0; i < 200; i++) begin
            send_byte(byte_t'($random(seed)), 1'b0);  // noise on rxd, dv low
        end
        send_idle(1);
        check_bit(busy_seen, 1'b0, "o_busy during idle stream");
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int                fd;
        int                c;
        int                r;
        int                nbytes;
        int                good;
        int                cnt;
        int                val;
        int                k;
        int                frames_run;
        logic [31:0]       mask;
        logic [8*160-1:0]  skip_line;
        rst         = 1'b1;
        rst_waddr   = 1'b0;
        eth_dv      = 1'b0;
        eth_rxd     = 4'h0;
        model_count = 0;
        frames_run  = 0;
        busy_prev   = 1'b0;
        repeat (5) @(posedge eth_clk);
        #2;
        rst = 1'b0;
        @(negedge eth_clk);
        check_bit(mem_wr.we, 1'b0, "o_mem_wr.we");
        check_bit(busy, 1'b0, "o_busy");
        check_bit(valid_packet, 1'b0, "o_valid_packet");
        check_count(packet_count, '0, "o_packet_count");
        mon_on = 1'b1;
        fd = $fopen("tests/eth_rx_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/eth_rx_input.txt");
            fail_run();
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                r = $fgets(skip_line, fd);
            end else if (c == "F") begin
                r = $fscanf(fd, "%d %d %d %h", nbytes, good, cnt, mask);
                frame_q.delete();
                for (k = 0; k < nbytes && r > 0; k++) begin
                    r = $fscanf(fd, "%h", val);
                    frame_q.push_back(byte_t'(val));
                end
                if (r <= 0) begin
                    $display("data file ended inside a frame record");
                    fail_run();
                end
                run_frame(good, cnt, mask);
                frames_run++;
            end else if (c == "R") begin
                request_ptr_reset();
            end else if (c == "X") begin
                send_random_idle();
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (frames_run == 0) begin
            $display("no frame records found in the data file");
            fail_run();
        end
        if (!failed) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: logic/eth_rx_top.sv
`timescale 1ns/1ps

module eth_rx_top
    import eth_frame_pkg::*, rx_buffer_pkg::*;
(
    input  logic       i_eth_clk,
    input  logic       i_rst,
    input  logic       i_rst_waddr,
    input  logic       i_eth_dv,
    input  logic [3:0] i_eth_rxd,
    output mem_wr_t    o_mem_wr,
    output logic       o_busy,
    output logic       o_valid_packet,
    output pkt_count_t o_packet_count
);

    rx_byte_t   rx_byte;     // byte stream out of the ddr capture
    logic       crc_clear;
    logic       crc_en;
    byte_t      crc_byte;
    logic       crc_ok;
    logic       pay_wr;
    byte_t      pay_byte;
    frame_end_t frame_end;

    rgmii_rx_ddr rgmii_rx_ddr_inst (
        .i_eth_clk (i_eth_clk),
        .i_rst     (i_rst),
        .i_eth_dv  (i_eth_dv),
        .i_eth_rxd (i_eth_rxd),
        .o_rx_byte (rx_byte)
    );

    eth_rx_parser eth_rx_parser_inst (
        .i_eth_clk   (i_eth_clk),
        .i_rst       (i_rst),
        .i_rx_byte   (rx_byte),
        .i_crc_ok    (crc_ok),
        .o_crc_clear (crc_clear),
        .o_crc_en    (crc_en),
        .o_crc_byte  (crc_byte),
        .o_pay_wr    (pay_wr),
        .o_pay_byte  (pay_byte),
        .o_frame_end (frame_end),
        .o_busy      (o_busy)
    );

    eth_crc32 eth_crc32_inst (
        .i_eth_clk (i_eth_clk),
        .i_rst     (i_rst),
        .i_clear   (crc_clear),
        .i_en      (crc_en),
        .i_byte    (crc_byte),
        .o_crc_ok  (crc_ok)
    );

    rx_buffer_addr rx_buffer_addr_inst (
        .i_eth_clk      (i_eth_clk),
        .i_rst          (i_rst),
        .i_rst_waddr    (i_rst_waddr),
        .i_busy         (o_busy),
        .i_pay_wr       (pay_wr),
        .i_pay_byte     (pay_byte),
        .i_frame_end    (frame_end),
        .o_mem_wr       (o_mem_wr),
        .o_valid_packet (o_valid_packet),
        .o_packet_count (o_packet_count)
    );

endmodule

// File: logic/rx_buffer_addr.sv
`timescale 1ns/1ps

module rx_buffer_addr
    import eth_frame_pkg::*, rx_buffer_pkg::*;
(
    input  logic       i_eth_clk,
    input  logic       i_rst,
    input  logic       i_rst_waddr,
    input  logic       i_busy,
    input  logic       i_pay_wr,
    input  byte_t      i_pay_byte,
    input  frame_end_t i_frame_end,
    output mem_wr_t    o_mem_wr,
    output logic       o_valid_packet,
    output pkt_count_t o_packet_count
);

    logic [1:0] waddr_rst_sync;
    logic       ptr_reset;
    buf_addr_t  wr_addr;
    buf_addr_t  slot_base;
    buf_addr_t  next_base;
    pkt_count_t next_count;

    function automatic buf_addr_t base_of(input pkt_count_t count);
        return buf_addr_t'(count) * buf_addr_t'(SLOT_BYTES);
    endfunction

    assign slot_base  = base_of(o_packet_count);
    assign next_count = (o_packet_count < pkt_count_t'(NUM_SLOTS - 1)) ?
                        o_packet_count + pkt_count_t'(1) : o_packet_count; // last slot is reused
    assign next_base  = base_of(next_count);
    assign ptr_reset  = waddr_rst_sync[1] && !i_busy; // never in mid frame

    // request comes from another clock domain
    always_ff @(posedge i_eth_clk) begin
        if (i_rst) begin
            waddr_rst_sync <= '0;
        end else begin
            waddr_rst_sync <= {waddr_rst_sync[0], i_rst_waddr};
        end
    end

    //////////////////////////////////////////////////
    // memory write port
    //////////////////////////////////////////////////

    always_ff @(posedge i_eth_clk) begin
        o_mem_wr.addr <= wr_addr;
        o_mem_wr.data <= i_pay_byte;
        if (i_rst) begin
            o_mem_wr.we <= 1'b0;
        end else begin
            o_mem_wr.we <= i_pay_wr;
        end
    end

    always_ff @(posedge i_eth_clk) begin
        if (i_rst) begin
            wr_addr        <= '0;
            o_packet_count <= '0;
            o_valid_packet <= 1'b0;
        end else begin
            o_valid_packet <= i_frame_end.done && i_frame_end.good;
            if (i_frame_end.done) begin
                if (i_frame_end.good) begin
                    o_packet_count <= next_count;
                    wr_addr        <= next_base;
                end else begin
                    wr_addr <= slot_base;  // rewind, slot gets overwritten
                end
            end else if (ptr_reset) begin
                o_packet_count <= '0;
                wr_addr        <= '0;
            end else if (i_pay_wr) begin
                wr_addr <= wr_addr + buf_addr_t'(1);
            end
        end
    end

    // parser length limit keeps every write inside the current slot
    assert property (@(posedge i_eth_clk) disable iff (i_rst)
        i_pay_wr |-> (wr_addr >= slot_base) &&
                     ((wr_addr - slot_base) < buf_addr_t'(SLOT_BYTES)));

endmodule

// File: logic/eth_rx_parser.sv
`timescale 1ns/1ps

module eth_rx_parser
    import eth_frame_pkg::*, rx_buffer_pkg::*;
(
    input  logic       i_eth_clk,
    input  logic       i_rst,
    input  rx_byte_t   i_rx_byte,
    input  logic       i_crc_ok,
    output logic       o_crc_clear,
    output logic       o_crc_en,
    output byte_t      o_crc_byte,
    output logic       o_pay_wr,
    output byte_t      o_pay_byte,
    output frame_end_t o_frame_end,
    output logic       o_busy
);

    parser_state_e state;
    mac_t          window;       // last six bytes, newest in the low byte
    mac_t          window_shift;
    payload_len_t  cnt;          // byte index inside the current field
    payload_len_t  pay_len;
    payload_len_t  len_next;
    logic          frame_bad;
    logic          dest_hit;
    logic          in_frame;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign window_shift = {window[39:0], i_rx_byte.data};
    assign len_next     = {pay_len[7:0], i_rx_byte.data}; // length is sent high byte first

    // sixth destination byte is arriving right now
    assign dest_hit = (state == IDLE) && i_rx_byte.valid && (window_shift == STATION_MAC);

    assign in_frame = (state == SOURCE) || (state == LENGTH) ||
                      (state == PAYLOAD) || (state == FCS);

    // crc runs six bytes behind the stream
    assign o_crc_clear = dest_hit;
    assign o_crc_en    = (in_frame && i_rx_byte.valid) || (state == DRAIN);
    assign o_crc_byte  = window[47:40];

    assign o_pay_wr   = (state == PAYLOAD) && i_rx_byte.valid;
    assign o_pay_byte = i_rx_byte.data;

    assign o_frame_end.done = (state == DONE);
    assign o_frame_end.good = (state == DONE) && i_crc_ok && !frame_bad;

    assign o_busy = (state != IDLE);

    //////////////////////////////////////////////////
    // frame fsm
    //////////////////////////////////////////////////

    always_ff @(posedge i_eth_clk) begin
        if (i_rst) begin
            state     <= IDLE;
            window    <= '0;
            cnt       <= '0;
            pay_len   <= '0;
            frame_bad <= 1'b0;
        end else if (in_frame && !i_rx_byte.valid) begin
            // dv dropped before the fcs was complete
            frame_bad <= 1'b1;
            state     <= DONE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_rx_byte.valid) begin
                        window <= window_shift;
                    end
                    if (dest_hit) begin
                        frame_bad <= 1'b0;
                        cnt       <= '0;
                        state     <= SOURCE;
                    end
                end

                SOURCE: begin
                    window <= window_shift;
                    if (cnt == payload_len_t'(MAC_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= LENGTH;
                    end else begin
                        cnt <= cnt + payload_len_t'(1);
                    end
                end

                LENGTH: begin
                    window  <= window_shift;
                    pay_len <= len_next;
                    if (cnt == payload_len_t'(LEN_BYTES - 1)) begin
                        cnt <= '0;
                        if (len_next == '0 || len_next > payload_len_t'(SLOT_BYTES)) begin
                            frame_bad <= 1'b1;   // would not fit a slot
                            state     <= DONE;
                        end else begin
                            state <= PAYLOAD;
                        end
                    end else begin
                        cnt <= cnt + payload_len_t'(1);
                    end
                end

                PAYLOAD: begin
                    window <= window_shift;
                    if (cnt == pay_len - payload_len_t'(1)) begin
                        cnt   <= '0;
                        state <= FCS;
                    end else begin
                        cnt <= cnt + payload_len_t'(1);
                    end
                end

                FCS: begin
                    window <= window_shift;
                    if (cnt == payload_len_t'(FCS_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= DRAIN;
                    end else begin
                        cnt <= cnt + payload_len_t'(1);
                    end
                end

                DRAIN: begin
                    window <= {window[39:0], 8'h00}; // push the tail into the crc
                    if (cnt == payload_len_t'(MAC_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= DONE;
                    end else begin
                        cnt <= cnt + payload_len_t'(1);
                    end
                end

                DONE: begin
                    window <= '0;  // fresh search
                    cnt    <= '0;
                    state  <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    assert property (@(posedge i_eth_clk) disable iff (i_rst)
        !$isunknown(state) && (state inside {IDLE, SOURCE, LENGTH, PAYLOAD, FCS, DRAIN, DONE}));

    // payload writes stay inside the announced length
    assert property (@(posedge i_eth_clk) disable iff (i_rst)
        o_pay_wr |-> (state == PAYLOAD) && (cnt < pay_len));

endmodule

// File: logic/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32
    import eth_frame_pkg::*;
(
    input  logic  i_eth_clk,
    input  logic  i_rst,
    input  logic  i_clear,
    input  logic  i_en,
    input  byte_t i_byte,
    output logic  o_crc_ok
);

    logic [31:0] crc_q;

    //////////////////////////////////////////////////
    // one byte through the reflected lfsr
    //////////////////////////////////////////////////

    function automatic logic [31:0] crc_fold(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        int          i;
        c = crc;
        for (i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin  // lsb of the byte goes first
                c = (c >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge i_eth_clk) begin
        if (i_rst) begin
            crc_q <= CRC_INIT;
        end else if (i_clear) begin
            crc_q <= CRC_INIT;
        end else if (i_en) begin
            crc_q <= crc_fold(crc_q, i_byte);
        end
    end

    // no final inversion, so a good frame leaves the magic residue
    assign o_crc_ok = (crc_q == CRC_RESIDUE);

endmodule

// File: logic/rgmii_rx_ddr.sv
`timescale 1ns/1ps

module rgmii_rx_ddr
    import eth_frame_pkg::*;
(
    input  logic       i_eth_clk,
    input  logic       i_rst,
    input  logic       i_eth_dv,
    input  logic [3:0] i_eth_rxd,
    output rx_byte_t   o_rx_byte
);

    logic [3:0] rise_nib;   // low nibble, rising edge
    logic [3:0] fall_nib;   // high nibble, falling edge
    logic [3:0] rise_d;
    logic [3:0] fall_d;     // high nibble back on the rising edge
    logic       dv_q;
    logic       dv_d;

    always_ff @(negedge i_eth_clk) begin
        fall_nib <= i_eth_rxd;
    end

    always_ff @(posedge i_eth_clk) begin
        rise_nib       <= i_eth_rxd;
        rise_d         <= rise_nib;
        fall_d         <= fall_nib;
        o_rx_byte.data <= {fall_d, rise_d}; // falling edge nibble on top
        if (i_rst) begin
            dv_q            <= 1'b0;
            dv_d            <= 1'b0;
            o_rx_byte.valid <= 1'b0;
        end else begin
            dv_q            <= i_eth_dv;
            dv_d            <= dv_q;
            o_rx_byte.valid <= dv_d;
        end
    end

    // the dv pipe and the nibble pipe must line up
    assert property (@(posedge i_eth_clk) disable iff (i_rst)
        o_rx_byte.valid |-> !$isunknown(o_rx_byte.data));

endmodule

// File: logic/rx_buffer_pkg.sv
package rx_buffer_pkg;

    import eth_frame_pkg::*;

    localparam int SLOT_BYTES = 1024;
    localparam int NUM_SLOTS  = 4;
    localparam int ADDR_W     = 12;  // NUM_SLOTS * SLOT_BYTES bytes
    localparam int COUNT_W    = 3;

    typedef logic [ADDR_W-1:0]  buf_addr_t;
    typedef logic [COUNT_W-1:0] pkt_count_t;
    typedef logic [15:0]        payload_len_t;

    // one write into the payload buffer
    typedef struct packed {
        logic      we;
        buf_addr_t addr;
        byte_t     data;
    } mem_wr_t;

    // end of frame report from the parser
    typedef struct packed {
        logic done;
        logic good;
    } frame_end_t;

endpackage

// File: logic/eth_frame_pkg.sv
package eth_frame_pkg;

    //////////////////////////////////////////////////
    // basic types
    //////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_t;

    // one byte of the receive stream
    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_byte_t;

    typedef enum logic [2:0] {
        IDLE,    // hunting for our destination
        SOURCE,
        LENGTH,
        PAYLOAD,
        FCS,
        DRAIN,   // flush window into the crc
        DONE
    } parser_state_e;

    //////////////////////////////////////////////////
    // frame format
    //////////////////////////////////////////////////

    localparam int MAC_BYTES = 6;
    localparam int LEN_BYTES = 2;
    localparam int FCS_BYTES = 4;

    // 1A goes out on the wire first
    localparam mac_t STATION_MAC = 48'h1A_2B_3C_4D_5E_6F;

    // crc-32 as used by 802.3
    localparam logic [31:0] CRC_INIT           = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;
    localparam logic [31:0] CRC_RESIDUE        = 32'hDEBB_20E3; // left over after a clean fcs

endpackage
